/* hdl/cnn_pkg.sv */
`default_nettype none

package cnn_pkg;

  // Pixel and weight words are signed two's complement
  localparam int WORD_WIDTH  = 8;
  localparam int ACC_WIDTH   = 24;
  localparam int OUT_WIDTH   = 16;
  localparam int CIN_MAX     = 16;
  localparam int LRELU_SHIFT = 3;

  // Channel count field holds 1 to CIN_MAX inclusive
  localparam int CIN_BITS = $clog2(CIN_MAX + 1);

  // Width of a channel index for a bank of n entries
  function automatic int idx_bits(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_RUN
  } layer_state_t;

  typedef enum logic {
    MODE_PLAIN,
    MODE_MAXPOOL
  } pool_mode_t;

  typedef struct packed {
    logic [CIN_BITS-1:0] cin;
    pool_mode_t          mode;
  } layer_cfg_t;

  typedef struct packed {
    logic signed [WORD_WIDTH-1:0] data;
    logic                         last;
  } word_beat_t;

  typedef struct packed {
    logic signed [OUT_WIDTH-1:0] data;
    logic                        last;
  } out_beat_t;

endpackage

`default_nettype wire

/* hdl/layer_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module layer_fsm (
  input  logic                  aclk,
  input  logic                  i_rst_n,
  input  logic                  i_start,
  input  cnn_pkg::layer_cfg_t   i_cfg,
  input  logic                  i_ch_last,
  input  logic                  i_w_fire,
  input  logic                  i_out_done,
  output cnn_pkg::layer_state_t o_state,
  output cnn_pkg::layer_cfg_t   o_cfg,
  output logic                  o_busy
);
  import cnn_pkg::*;

  layer_state_t state_q;
  layer_state_t state_d;
  layer_cfg_t   cfg_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (i_start) begin
          state_d = ST_LOAD;
        end
      end
      ST_LOAD: begin
        // The weight on the last channel completes the bank
        if (i_w_fire && i_ch_last) begin
          state_d = ST_RUN;
        end
      end
      ST_RUN: begin
        if (i_out_done) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Configuration is only taken while idle so a running layer keeps its setup
  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cfg_q.cin  <= CIN_BITS'(1);
      cfg_q.mode <= MODE_PLAIN;
    end else if (state_q == ST_IDLE && i_start) begin
      cfg_q <= i_cfg;
    end
  end

  assign o_state = state_q;
  assign o_cfg   = cfg_q;
  assign o_busy  = (state_q != ST_IDLE);

endmodule

`default_nettype wire

/* hdl/channel_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_counter #(
  parameter  int CIN_MAX_P = cnn_pkg::CIN_MAX,
  localparam int IDX_W     = cnn_pkg::idx_bits(CIN_MAX_P)
) (
  input  logic                         aclk,
  input  logic                         i_rst_n,
  input  cnn_pkg::layer_state_t        i_state,
  input  logic [cnn_pkg::CIN_BITS-1:0] i_cin,
  input  logic                         i_step,
  output logic [IDX_W-1:0]             o_ch_idx,
  output logic                         o_ch_last
);
  import cnn_pkg::*;

  logic [IDX_W-1:0] idx_q;
  layer_state_t     state_q;
  logic             state_change;

  // The last channel is cin-1, and the same flag ends a weight load and a pixel
  assign o_ch_last = ((CIN_BITS'(idx_q) + 1'b1) == i_cin);

  assign state_change = (i_state != state_q);

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= i_state;
    end
  end

  // A beat taken in the first cycle of a new state still counts because the step
  // wins over the clear
  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      idx_q <= '0;
    end else if (i_state == ST_IDLE) begin
      idx_q <= '0;
    end else if (i_step) begin
      if (o_ch_last) begin
        idx_q <= '0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end else if (state_change) begin
      idx_q <= '0;
    end
  end

  assign o_ch_idx = idx_q;

endmodule

`default_nettype wire

/* hdl/weight_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_bank #(
  parameter  int CIN_MAX_P = cnn_pkg::CIN_MAX,
  localparam int IDX_W     = cnn_pkg::idx_bits(CIN_MAX_P)
) (
  input  logic                                aclk,
  input  logic                                i_rst_n,
  input  logic                                i_we,
  input  logic [IDX_W-1:0]                    i_addr,
  input  logic signed [cnn_pkg::WORD_WIDTH-1:0] i_wdata,
  output logic signed [cnn_pkg::WORD_WIDTH-1:0] o_rdata
);
  import cnn_pkg::*;

  logic signed [WORD_WIDTH-1:0] bank_q [CIN_MAX_P];

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < CIN_MAX_P; i++) begin
        bank_q[i] <= '0;
      end
    end else if (i_we) begin
      bank_q[i_addr] <= i_wdata;
    end
  end

  // Read port follows the channel index of the pixel in the same cycle
  assign o_rdata = bank_q[i_addr];

endmodule

`default_nettype wire

/* hdl/mac_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mac_unit (
  input  logic                                 aclk,
  input  logic                                 i_rst_n,
  input  logic                                 i_fire,
  input  cnn_pkg::word_beat_t                  i_px,
  input  logic signed [cnn_pkg::WORD_WIDTH-1:0] i_weight,
  input  logic                                 i_ch_first,
  input  logic                                 i_ch_last,
  input  logic                                 i_stall,
  output logic                                 o_acc_valid,
  output logic signed [cnn_pkg::ACC_WIDTH-1:0] o_acc,
  output logic                                 o_acc_last
);
  import cnn_pkg::*;

  localparam int PROD_WIDTH = 2 * WORD_WIDTH;

  logic signed [PROD_WIDTH-1:0] prod;
  logic signed [ACC_WIDTH-1:0]  prod_ext;
  logic signed [ACC_WIDTH-1:0]  base;
  logic signed [ACC_WIDTH-1:0]  sum;
  logic signed [ACC_WIDTH-1:0]  acc_q;

  assign prod     = i_px.data * i_weight;
  assign prod_ext = {{(ACC_WIDTH - PROD_WIDTH){prod[PROD_WIDTH-1]}}, prod};

  // First channel starts a fresh sum instead of clearing the register a cycle early
  assign base = i_ch_first ? '0 : acc_q;
  assign sum  = base + prod_ext;

  always_ff @(posedge aclk) begin
    if (i_fire) begin
      acc_q <= sum;
    end
  end

  // Separate result register so the next pixel can accumulate behind it
  always_ff @(posedge aclk) begin
    if (i_fire && i_ch_last) begin
      o_acc      <= sum;
      o_acc_last <= i_px.last;
    end
  end

  // Held while stalled until the activation stage takes it
  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_acc_valid <= 1'b0;
    end else if (!i_stall) begin
      o_acc_valid <= i_fire && i_ch_last;
    end
  end

endmodule

`default_nettype wire

/* hdl/lrelu_maxpool.sv */
`timescale 1ns/1ps
`default_nettype none

module lrelu_maxpool #(
  parameter int LRELU_SHIFT_P = cnn_pkg::LRELU_SHIFT
) (
  input  logic                                 aclk,
  input  logic                                 i_rst_n,
  input  cnn_pkg::pool_mode_t                  i_mode,
  input  logic                                 i_acc_valid,
  input  logic signed [cnn_pkg::ACC_WIDTH-1:0] i_acc,
  input  logic                                 i_acc_last,
  input  logic                                 i_m_ready,
  output logic                                 o_m_valid,
  output cnn_pkg::out_beat_t                   o_m_beat,
  output logic                                 o_stall,
  output logic                                 o_done
);
  import cnn_pkg::*;

  localparam logic signed [ACC_WIDTH-1:0] SAT_MAX =
    {{(ACC_WIDTH - OUT_WIDTH + 1){1'b0}}, {(OUT_WIDTH - 1){1'b1}}};
  localparam logic signed [ACC_WIDTH-1:0] SAT_MIN = ~SAT_MAX;

  logic signed [ACC_WIDTH-1:0] leaky;
  logic signed [OUT_WIDTH-1:0] act;
  logic signed [OUT_WIDTH-1:0] first_q;
  logic signed [OUT_WIDTH-1:0] pair_max;
  logic                        have_first;
  logic                        pooling;
  logic                        take;
  logic                        emit;

  // Negative slope is alpha = 2^-LRELU_SHIFT_P
  always_comb begin
    leaky = i_acc[ACC_WIDTH-1] ? (i_acc >>> LRELU_SHIFT_P) : i_acc;
    if (leaky > SAT_MAX) begin
      act = SAT_MAX[OUT_WIDTH-1:0];
    end else if (leaky < SAT_MIN) begin
      act = SAT_MIN[OUT_WIDTH-1:0];
    end else begin
      act = leaky[OUT_WIDTH-1:0];
    end
  end

  assign pair_max = (first_q > act) ? first_q : act;
  assign pooling  = (i_mode == MODE_MAXPOOL);

  // A full output register that is not being drained blocks the whole chain
  assign o_stall = o_m_valid && !i_m_ready;
  assign take    = i_acc_valid && !o_stall;

  // Pool mode emits on the second of a pair, or on a lone final result
  assign emit = take && (!pooling || have_first || i_acc_last);

  assign o_done = o_m_valid && i_m_ready && o_m_beat.last;

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_m_valid  <= 1'b0;
      have_first <= 1'b0;
    end else begin
      if (emit) begin
        o_m_valid <= 1'b1;
      end else if (i_m_ready) begin
        o_m_valid <= 1'b0;
      end
      if (take && pooling) begin
        have_first <= !have_first && !i_acc_last;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take && !emit) begin
      first_q <= act;
    end
    if (emit) begin
      o_m_beat.data <= (pooling && have_first) ? pair_max : act;
      o_m_beat.last <= i_acc_last;
    end
  end

endmodule

`default_nettype wire

/* hdl/conv_layer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_layer_top #(
  parameter int CIN_MAX_P     = cnn_pkg::CIN_MAX,
  parameter int LRELU_SHIFT_P = cnn_pkg::LRELU_SHIFT
) (
  input  logic                aclk,
  input  logic                i_rst_n,

  input  logic                i_w_valid,
  output logic                o_w_ready,
  input  cnn_pkg::word_beat_t i_w_beat,

  input  logic                i_px_valid,
  output logic                o_px_ready,
  input  cnn_pkg::word_beat_t i_px_beat,

  output logic                o_m_valid,
  input  logic                i_m_ready,
  output cnn_pkg::out_beat_t  o_m_beat,

  input  logic                i_start,
  input  cnn_pkg::layer_cfg_t i_cfg,
  output logic                o_busy
);
  import cnn_pkg::*;

  localparam int IDX_W = idx_bits(CIN_MAX_P);

  layer_state_t                state;
  layer_cfg_t                  cfg;
  logic [IDX_W-1:0]            ch_idx;
  logic                        ch_last;
  logic                        ch_first;
  logic                        w_fire;
  logic                        px_fire;
  logic                        stall;
  logic                        out_done;
  logic signed [WORD_WIDTH-1:0] weight;
  logic                        acc_valid;
  logic signed [ACC_WIDTH-1:0] acc;
  logic                        acc_last;

  assign o_w_ready  = (state == ST_LOAD);
  assign o_px_ready = (state == ST_RUN) && !stall;

  assign w_fire   = i_w_valid && o_w_ready;
  assign px_fire  = i_px_valid && o_px_ready;
  assign ch_first = (ch_idx == '0);

  layer_fsm u_fsm (
    .aclk       (aclk),
    .i_rst_n    (i_rst_n),
    .i_start    (i_start),
    .i_cfg      (i_cfg),
    .i_ch_last  (ch_last),
    .i_w_fire   (w_fire),
    .i_out_done (out_done),
    .o_state    (state),
    .o_cfg      (cfg),
    .o_busy     (o_busy)
  );

  // Weights and pixels share one index, since the two streams never overlap
  channel_counter #(
    .CIN_MAX_P (CIN_MAX_P)
  ) u_counter (
    .aclk      (aclk),
    .i_rst_n   (i_rst_n),
    .i_state   (state),
    .i_cin     (cfg.cin),
    .i_step    (w_fire || px_fire),
    .o_ch_idx  (ch_idx),
    .o_ch_last (ch_last)
  );

  weight_bank #(
    .CIN_MAX_P (CIN_MAX_P)
  ) u_weights (
    .aclk    (aclk),
    .i_rst_n (i_rst_n),
    .i_we    (w_fire),
    .i_addr  (ch_idx),
    .i_wdata (i_w_beat.data),
    .o_rdata (weight)
  );

  mac_unit u_mac (
    .aclk        (aclk),
    .i_rst_n     (i_rst_n),
    .i_fire      (px_fire),
    .i_px        (i_px_beat),
    .i_weight    (weight),
    .i_ch_first  (ch_first),
    .i_ch_last   (ch_last),
    .i_stall     (stall),
    .o_acc_valid (acc_valid),
    .o_acc       (acc),
    .o_acc_last  (acc_last)
  );

  lrelu_maxpool #(
    .LRELU_SHIFT_P (LRELU_SHIFT_P)
  ) u_act (
    .aclk        (aclk),
    .i_rst_n     (i_rst_n),
    .i_mode      (cfg.mode),
    .i_acc_valid (acc_valid),
    .i_acc       (acc),
    .i_acc_last  (acc_last),
    .i_m_ready   (i_m_ready),
    .o_m_valid   (o_m_valid),
    .o_m_beat    (o_m_beat),
    .o_stall     (stall),
    .o_done      (out_done)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 3,
  parameter int RELEASE_DLY  = 10
) (
  output logic o_aclk,
  output logic o_rst_n
);

  initial begin
    o_aclk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) o_aclk = ~o_aclk;
    end
  end

  // Reset leaves just after an edge, like every other driven input
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_aclk);
    #RELEASE_DLY;
    o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/conv_layer_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_layer_asserts (
  input logic                  aclk,
  input logic                  i_rst_n,
  input logic                  o_w_ready,
  input logic                  o_px_ready,
  input logic                  o_m_valid,
  input logic                  i_m_ready,
  input cnn_pkg::out_beat_t    o_m_beat,
  input cnn_pkg::layer_state_t i_state
);
  import cnn_pkg::*;

  // A stalled output beat must not move or drop
  output_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (o_m_valid && !i_m_ready) |=> (o_m_valid && $stable(o_m_beat)))
    else $error("output beat changed while i_m_ready was low");

  reset_quiet: assert property (@(posedge aclk)
    $rose(i_rst_n) |-> (!o_w_ready && !o_px_ready && !o_m_valid))
    else $error("ready or valid output high right after reset");

  // The run state is only reached through a weight load
  px_ready_in_run: assert property (@(posedge aclk) disable iff (!i_rst_n)
    o_px_ready |-> ((i_state == ST_RUN) && $past(i_state != ST_IDLE)))
    else $error("o_px_ready high outside a run entered from a weight load");

endmodule

`default_nettype wire

/* testbench/conv_layer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_layer_tb;
  import cnn_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;
  localparam int N_ENTRIES  = 6;
  localparam int MAX_PIX    = 8;
  localparam logic [31:0] SEED = 32'hfbabd83c;

  // Stimulus table with the weight of channel c in bits [8c+7:8c]
  localparam int T_CIN [N_ENTRIES]  = '{4, 4, 1, 16, 16, 4};
  localparam bit T_POOL [N_ENTRIES] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
  localparam int T_NPIX [N_ENTRIES] = '{6, 5, 4, 3, 7, 6};
  localparam logic [127:0] T_W [N_ENTRIES] = '{
    128'h0000_0000_0000_0000_0000_0000_817f_fe03,
    128'h0000_0000_0000_0000_0000_0000_f011_c040,
    128'h0000_0000_0000_0000_0000_0000_0000_0085,
    128'h7f7f_7f7f_7f7f_7f7f_7f7f_7f7f_7f7f_7f7f,
    128'h807f_807f_807f_807f_807f_807f_807f_807f,
    128'h0000_0000_0000_0000_0000_0000_0102_fffd
  };

  logic       aclk;
  logic       rst_n;
  logic       w_valid;
  logic       w_ready;
  word_beat_t w_beat;
  logic       px_valid;
  logic       px_ready;
  word_beat_t px_beat;
  logic       m_valid;
  logic       m_ready;
  out_beat_t  m_beat;
  logic       start;
  layer_cfg_t cfg;
  logic       busy;

  logic [31:0]       lfsr_q;
  logic signed [7:0] t_px [N_ENTRIES][MAX_PIX][16];
  out_beat_t         exp_q[$];
  int                n_checked;

  tb_clock #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (3),
    .RELEASE_DLY  (DRIVE_DLY)
  ) u_clock (
    .o_aclk  (aclk),
    .o_rst_n (rst_n)
  );

  conv_layer_top #(
    .CIN_MAX_P     (CIN_MAX),
    .LRELU_SHIFT_P (LRELU_SHIFT)
  ) dut (
    .aclk       (aclk),
    .i_rst_n    (rst_n),
    .i_w_valid  (w_valid),
    .o_w_ready  (w_ready),
    .i_w_beat   (w_beat),
    .i_px_valid (px_valid),
    .o_px_ready (px_ready),
    .i_px_beat  (px_beat),
    .o_m_valid  (m_valid),
    .i_m_ready  (m_ready),
    .o_m_beat   (m_beat),
    .i_start    (start),
    .i_cfg      (cfg),
    .o_busy     (busy)
  );

  bind conv_layer_top conv_layer_asserts u_asserts (
    .aclk       (aclk),
    .i_rst_n    (i_rst_n),
    .o_w_ready  (o_w_ready),
    .o_px_ready (o_px_ready),
    .o_m_valid  (o_m_valid),
    .i_m_ready  (i_m_ready),
    .o_m_beat   (o_m_beat),
    .i_state    (state)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic int activate(input int acc);
    int v;
    v = (acc < 0) ? (acc >>> LRELU_SHIFT) : acc;
    if (v > 32767) v = 32767;
    if (v < -32768) v = -32768;
    return v;
  endfunction

  function automatic int total_outputs();
    int n;
    n = 0;
    for (int e = 0; e < N_ENTRIES; e++) begin
      n += T_POOL[e] ? (T_NPIX[e] + 1) / 2 : T_NPIX[e];
    end
    return n;
  endfunction

  function automatic longint watchdog_ns();
    longint beats;
    beats = 0;
    for (int e = 0; e < N_ENTRIES; e++) begin
      beats += T_CIN[e] * (1 + T_NPIX[e]);
    end
    return (beats * 20 + 40) * CLK_PERIOD;
  endfunction

  task automatic push_expected(input int v, input logic last);
    out_beat_t b;
    b.data = 16'(v);
    b.last = last;
    exp_q.push_back(b);
  endtask

  task automatic build_expected(input int e);
    int res [MAX_PIX];
    int acc;
    int p;
    for (p = 0; p < T_NPIX[e]; p++) begin
      acc = 0;
      for (int c = 0; c < T_CIN[e]; c++) begin
        acc += int'(t_px[e][p][c]) * int'($signed(T_W[e][8*c +: 8]));
      end
      res[p] = activate(acc);
    end
    if (!T_POOL[e]) begin
      for (p = 0; p < T_NPIX[e]; p++) begin
        push_expected(res[p], p == T_NPIX[e] - 1);
      end
    end else begin
      for (p = 0; p < T_NPIX[e]; p += 2) begin
        if (p + 1 < T_NPIX[e]) begin
          push_expected((res[p] > res[p+1]) ? res[p] : res[p+1], p + 1 == T_NPIX[e] - 1);
        end else begin
          push_expected(res[p], 1'b1);
        end
      end
    end
  endtask

  task automatic send_weight(input logic signed [7:0] d);
    w_valid     = 1'b1;
    w_beat.data = d;
    w_beat.last = 1'b0;
    do @(negedge aclk); while (!w_ready);
    @(posedge aclk);
    #DRIVE_DLY;
    w_valid = 1'b0;
  endtask

  task automatic send_pixel(input logic signed [7:0] d, input logic last);
    px_valid     = 1'b1;
    px_beat.data = d;
    px_beat.last = last;
    do @(negedge aclk); while (!px_ready);
    @(posedge aclk);
    #DRIVE_DLY;
    px_valid = 1'b0;
  endtask

  task automatic run_layer(input int e);
    build_expected(e);
    @(posedge aclk);
    #DRIVE_DLY;
    cfg.cin  = CIN_BITS'(T_CIN[e]);
    cfg.mode = T_POOL[e] ? MODE_MAXPOOL : MODE_PLAIN;
    start    = 1'b1;
    @(posedge aclk);
    #DRIVE_DLY;
    start = 1'b0;
    // Each stream is offered in the very first cycle of its state
    for (int c = 0; c < T_CIN[e]; c++) begin
      send_weight($signed(T_W[e][8*c +: 8]));
    end
    for (int p = 0; p < T_NPIX[e]; p++) begin
      for (int c = 0; c < T_CIN[e]; c++) begin
        send_pixel(t_px[e][p][c], (p == T_NPIX[e] - 1) && (c == T_CIN[e] - 1));
      end
    end
    while (busy) @(negedge aclk);
    assert (exp_q.size() == 0)
      else fail_run($sformatf("layer %0d went idle with %0d outputs missing", e, exp_q.size()));
  endtask

  task automatic check_output();
    out_beat_t want;
    assert (exp_q.size() != 0)
      else fail_run("output beat arrived when none was expected");
    want = exp_q.pop_front();
    assert (m_beat.data == want.data)
      else fail_run($sformatf("mismatch o_m_beat.data: got %h expected %h",
                              m_beat.data, want.data));
    assert (m_beat.last == want.last)
      else fail_run($sformatf("mismatch o_m_beat.last: got %h expected %h",
                              m_beat.last, want.last));
    n_checked++;
  endtask

  // Outputs are sampled mid-cycle where the handshake is settled
  initial begin
    forever begin
      @(negedge aclk);
      if (rst_n && m_valid && m_ready) check_output();
    end
  end

  initial begin
    m_ready = 1'b0;
    @(posedge rst_n);
    forever begin
      @(posedge aclk);
      #DRIVE_DLY;
      m_ready = (rand_bits(2) != 0);
    end
  end

  initial begin
    #(watchdog_ns());
    fail_run("watchdog expired before all layers finished");
  end

  initial begin
    w_valid   = 1'b0;
    w_beat    = '0;
    px_valid  = 1'b0;
    px_beat   = '0;
    start     = 1'b0;
    cfg       = '0;
    n_checked = 0;
    lfsr_q    = SEED;
    for (int e = 0; e < N_ENTRIES; e++) begin
      for (int p = 0; p < T_NPIX[e]; p++) begin
        for (int c = 0; c < T_CIN[e]; c++) begin
          t_px[e][p][c] = 8'(rand_bits(8));
        end
      end
    end
    wait (rst_n);
    @(negedge aclk);
    assert (!w_ready && !px_ready && !m_valid && !busy)
      else fail_run("a ready, valid or busy output is high after reset");
    for (int e = 0; e < N_ENTRIES; e++) begin
      run_layer(e);
    end
    if (n_checked == total_outputs()) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      fail_run($sformatf("only %0d of %0d outputs were checked", n_checked, total_outputs()));
    end
  end

endmodule

`default_nettype wire

/* src.f */
hdl/cnn_pkg.sv
hdl/layer_fsm.sv
hdl/channel_counter.sv
hdl/weight_bank.sv
hdl/mac_unit.sv
hdl/lrelu_maxpool.sv
hdl/conv_layer_top.sv
testbench/tb_clock.sv
testbench/conv_layer_asserts.sv
testbench/conv_layer_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the conv layer testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module conv_layer_tb -o conv_layer_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/conv_layer_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
